//--- all.f
+incdir+include
src/isa_pkg.sv
src/bus_pkg.sv
src/fetch.sv
src/decode.sv
src/exec.sv
src/writeback.sv
src/eightbit.sv
sim/tb_mem.sv
sim/tb_eightbit.sv

//--- include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_DATA_W   8
`define CPU_ADDR_W   8
`define CPU_INST_W   16
`define CPU_NUM_REGS 16

// First instruction is fetched from here after reset
`define CPU_RESET_PC 8'h00

`endif

//--- run.sh
#!/bin/sh
# Build and run the eightbit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_eightbit -o sim_eightbit

./obj_dir/sim_eightbit > run.log 2>&1 || true
cat run.log

if grep -q "SIMULATION PASSED" run.log; then
    exit 0
fi
exit 1

//--- sim/tb_eightbit.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module tb_eightbit;

    localparam int OP_JMP  = 0;
    localparam int OP_LOD  = 1;
    localparam int OP_STR  = 2;
    localparam int OP_ADD  = 3;
    localparam int OP_ADDI = 4;
    localparam int OP_LODI = 5;
    localparam int OP_NAND = 6;
    localparam int OP_JEQZ = 7;
    localparam int LIMIT   = 5000;

    logic                   clk;
    logic                   rst;
    logic                   mem_req;
    logic                   we;
    logic                   mem_ready;
    logic [`CPU_ADDR_W-1:0] addr;
    logic [`CPU_DATA_W-1:0] data_out;
    logic [`CPU_DATA_W-1:0] data_in;
    logic [7:0]             img [0:255];
    logic [15:0]            exp_q[$];
    logic [7:0]             end_pc;
    int                     n_words;
    int                     errors;
    int                     pass_count;
    int                     fail_count;

    eightbit dut_i (
        .clk       (clk),
        .rst       (rst),
        .mem_ready (mem_ready),
        .data_in   (data_in),
        .mem_req   (mem_req),
        .we        (we),
        .addr      (addr),
        .data_out  (data_out)
    );

    tb_mem mem_i (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .we        (we),
        .addr      (addr),
        .wdata     (data_out),
        .mem_ready (mem_ready),
        .data_in   (data_in)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [15:0] enc(int op, int r0, int r1, int r2);
        return {op[3:0], r0[3:0], r1[3:0], r2[3:0]};
    endfunction

    function automatic logic [15:0] enc_imm(int op, int r0, int imm);
        return {op[3:0], r0[3:0], imm[7:0]};
    endfunction

    task automatic emit(logic [15:0] w);
        img[2*n_words]   = w[15:8];
        img[2*n_words+1] = w[7:0];
        n_words++;
    endtask

    task automatic emit_halt();
        emit(enc_imm(OP_LODI, 15, 2*n_words + 2));
        emit(enc(OP_JMP, 15, 0, 0));                  // Jump to itself
    endtask

    task automatic build_prog(int id);
        n_words = 0;
        for (int a = 0; a < 256; a++)
            img[a] = 8'(a * 37 + 17);
        case (id)
            0: begin                                   // Arithmetic
                emit(enc_imm(OP_LODI, 1, 8'h3c));
                emit(enc_imm(OP_LODI, 2, 8'h91));
                emit(enc(OP_ADD, 3, 1, 2));
                emit(enc(OP_ADDI, 4, 3, 7));
                emit(enc(OP_NAND, 5, 1, 2));
                emit(enc_imm(OP_LODI, 10, 8'h80));
                emit(enc(OP_STR, 3, 10, 0));
                emit(enc(OP_ADDI, 10, 10, 1));
                emit(enc(OP_STR, 4, 10, 0));
                emit(enc(OP_ADDI, 10, 10, 1));
                emit(enc(OP_STR, 5, 10, 0));
                emit_halt();
            end
            1: begin                                   // Load then store
                img[8'h90] = 8'ha7;
                img[8'h91] = 8'h4e;
                emit(enc_imm(OP_LODI, 1, 8'h90));
                emit(enc(OP_LOD, 2, 1, 0));
                emit(enc(OP_ADDI, 1, 1, 1));
                emit(enc(OP_LOD, 3, 1, 0));
                emit(enc(OP_NAND, 4, 2, 3));
                emit(enc_imm(OP_LODI, 8, 8'ha0));
                emit(enc(OP_STR, 2, 8, 0));
                emit(enc(OP_ADDI, 8, 8, 1));
                emit(enc(OP_STR, 4, 8, 0));
                emit_halt();
            end
            default: begin                             // Branches with fixed target addresses
                emit(enc_imm(OP_LODI, 1, 8'h00));
                emit(enc_imm(OP_LODI, 2, 8'h05));
                emit(enc_imm(OP_LODI, 8, 8'hb0));
                emit(enc_imm(OP_LODI, 9, 8'h0e));
                emit(enc(OP_JEQZ, 9, 1, 0));           // Taken
                emit(enc(OP_STR, 2, 8, 0));
                emit(enc(OP_STR, 8, 8, 0));
                emit(enc(OP_JEQZ, 9, 2, 0));           // Not taken at 0x0e
                emit(enc(OP_STR, 2, 8, 0));
                emit(enc_imm(OP_LODI, 10, 8'h18));
                emit(enc(OP_JMP, 10, 0, 0));
                emit(enc(OP_STR, 8, 8, 0));
                emit(enc(OP_ADDI, 8, 8, 1));           // 0x18
                emit(enc(OP_STR, 1, 8, 0));
                emit_halt();
            end
        endcase
    endtask

    // ISA reference model that collects the expected stores
    task automatic run_model();
        logic [7:0]  r [0:15];
        logic [7:0]  m [0:255];
        logic [7:0]  pc;
        logic [7:0]  nxt;
        logic [15:0] i;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic [3:0]  rc;
        logic        done;
        for (int k = 0; k < 16; k++)
            r[k] = '0;
        for (int k = 0; k < 256; k++)
            m[k] = img[k];
        exp_q.delete();
        pc   = `CPU_RESET_PC;
        done = 1'b0;
        for (int step = 0; step < 300 && !done; step++) begin
            i   = {m[pc], m[pc + 8'd1]};
            ra  = i[11:8];
            rb  = i[7:4];
            rc  = i[3:0];
            nxt = pc + 8'd2;
            case (int'(i[15:12]))
                OP_JMP:  nxt = r[ra];
                OP_LOD:  r[ra] = m[r[rb]];
                OP_STR: begin
                    m[r[rb]] = r[ra];
                    exp_q.push_back({r[rb], r[ra]});
                end
                OP_ADD:  r[ra] = r[rb] + r[rc];
                OP_ADDI: r[ra] = r[rb] + {4'b0, rc};    // Immediate is the r2 nibble
                OP_LODI: r[ra] = i[7:0];
                OP_NAND: r[ra] = ~(r[rb] & r[rc]);
                OP_JEQZ: if (r[rb] == 8'h00) nxt = r[ra];
                default: ;
            endcase
            if (nxt == pc)
                done = 1'b1;
            pc = nxt;
        end
        end_pc = pc;
    endtask

    function automatic int count_reads(logic [7:0] a);
        int n;
        n = 0;
        foreach (mem_i.read_q[k])
            if (mem_i.read_q[k] == a)
                n++;
        return n;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #1 rst <= 1'b1;
        repeat (3) @(posedge clk);
        assert (mem_req == 1'b0) else begin
            $display("ERR %0t mem_req got %b expected 0", $time, mem_req);
            errors++;
        end
        assert (we == 1'b0) else begin
            $display("ERR %0t we got %b expected 0", $time, we);
            errors++;
        end
        #1 rst <= 1'b0;
    endtask

    task automatic run_test(string name, int prog, int delay);
        int          start;
        int          t;
        logic [15:0] got;
        logic [15:0] want;
        start = errors + mem_i.errors;
        build_prog(prog);
        run_model();
        for (int a = 0; a < 256; a++)
            mem_i.mem[a] = img[a];
        mem_i.max_delay = delay;
        apply_reset();
        for (t = 0; t < LIMIT && mem_i.read_q.size() < 2; t++)
            @(posedge clk);
        if (t == LIMIT) begin
            $display("%0t: no instruction fetch after reset in %s", $time, name);
            errors++;
        end else begin
            assert (mem_i.read_q[0] == 8'h00 && mem_i.read_q[1] == 8'h01) else begin
                $display("ERR %0t addr got %h %h expected 00 01", $time,
                         mem_i.read_q[0], mem_i.read_q[1]);
                errors++;
            end
        end
        for (t = 0; t < LIMIT && mem_i.store_q.size() < exp_q.size(); t++)
            @(posedge clk);
        if (t == LIMIT) begin
            $display("%0t: timed out waiting for stores in %s", $time, name);
            errors++;
        end
        for (t = 0; t < LIMIT && count_reads(end_pc) < 3; t++)   // Self jump taken twice
            @(posedge clk);
        if (t == LIMIT) begin
            $display("%0t: program end never reached in %s", $time, name);
            errors++;
        end
        while (mem_i.store_q.size() > 0 && exp_q.size() > 0) begin
            got  = mem_i.store_q.pop_front();
            want = exp_q.pop_front();
            assert (got[15:8] == want[15:8]) else begin
                $display("ERR %0t store addr got %h expected %h", $time, got[15:8], want[15:8]);
                errors++;
            end
            assert (got[7:0] == want[7:0]) else begin
                $display("ERR %0t data_out got %h expected %h", $time, got[7:0], want[7:0]);
                errors++;
            end
        end
        assert (mem_i.store_q.size() == 0) else begin
            $display("%0t: core made a store the model did not expect in %s", $time, name);
            errors++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0t: an expected store never happened in %s", $time, name);
            errors++;
        end
        if (errors + mem_i.errors == start) begin
            pass_count++;
            $display("test %s (delay %0d): ok", name, delay);
        end else begin
            fail_count++;
            $display("test %s (delay %0d): failed", name, delay);
        end
    endtask

    initial begin
        rst        = 1'b1;
        errors     = 0;
        pass_count = 0;
        fail_count = 0;
        n_words    = 0;
        run_test("arith", 0, 0);
        run_test("load_store", 1, 0);
        run_test("branch", 2, 0);
        run_test("arith", 0, 1);
        run_test("arith", 0, 3);
        run_test("arith", 0, 7);
        run_test("load_store", 1, 5);
        run_test("branch", 2, 7);
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0 && errors + mem_i.errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module tb_mem (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    mem_req,
    input  wire                    we,
    input  wire [`CPU_ADDR_W-1:0]  addr,
    input  wire [`CPU_DATA_W-1:0]  wdata,
    output logic                   mem_ready,
    output logic [`CPU_DATA_W-1:0] data_in
);

    logic [`CPU_DATA_W-1:0] mem [0:255];
    logic [15:0]            store_q[$];                 // {addr, data} per write
    logic [`CPU_ADDR_W-1:0] read_q[$];
    int                     max_delay;
    int                     errors;
    int                     wait_cnt;
    logic                   counting;
    logic [31:0]            lfsr;
    logic                   rst_s;
    logic                   prev_req;
    logic                   prev_we;
    logic                   prev_ready;
    logic [`CPU_ADDR_W-1:0] prev_addr;
    logic [`CPU_DATA_W-1:0] prev_wdata;

    initial begin
        lfsr       = 32'h12e4_d3ee;
        mem_ready  = 1'b0;
        data_in    = '0;
        errors     = 0;
        max_delay  = 0;
        counting   = 1'b0;
        wait_cnt   = 0;
        prev_req   = 1'b0;
        prev_ready = 1'b0;
    end

    // Galois LFSR stepped once per bit
    function logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h8020_0003;
        return b;
    endfunction

    function int rand_delay();
        int v;
        v = 0;
        if (max_delay == 0)
            return 0;
        for (int i = 0; i < 3; i++)
            v = (v << 1) | int'(next_bit());
        return v % (max_delay + 1);
    endfunction

    always @(posedge clk) begin
        rst_s = rst;
        #1;
        if (rst_s) begin
            mem_ready = 1'b0;
            counting  = 1'b0;
            store_q.delete();
            read_q.delete();
        end else begin
            if (prev_req && !prev_ready) begin
                assert (mem_req) else begin
                    $display("%0t: mem_req fell before mem_ready was given", $time);
                    errors++;
                end
                assert (addr == prev_addr && we == prev_we && wdata == prev_wdata) else begin
                    $display("%0t: bus fields changed while waiting for mem_ready", $time);
                    errors++;
                end
            end
            if (prev_req && prev_ready) begin
                assert (!mem_req) else begin
                    $display("%0t: mem_req still high after mem_ready was seen", $time);
                    errors++;
                end
            end
            if (!prev_req && mem_req) begin
                assert (!prev_ready) else begin
                    $display("%0t: mem_req raised before mem_ready fell", $time);
                    errors++;
                end
            end
            if (mem_ready) begin
                if (!mem_req) begin
                    if (!counting) begin
                        counting = 1'b1;
                        wait_cnt = rand_delay();
                    end
                    if (wait_cnt == 0) begin
                        counting  = 1'b0;
                        mem_ready = 1'b0;               // Ready lingers a random time
                    end else begin
                        wait_cnt--;
                    end
                end
            end else if (mem_req) begin
                if (!counting) begin
                    counting = 1'b1;
                    wait_cnt = rand_delay();
                end
                if (wait_cnt == 0) begin
                    counting  = 1'b0;
                    mem_ready = 1'b1;
                    if (we) begin
                        mem[addr] = wdata;
                        store_q.push_back({addr, wdata});
                    end else begin
                        data_in = mem[addr];
                        read_q.push_back(addr);
                    end
                end else begin
                    wait_cnt--;
                end
            end
        end
        prev_req   = mem_req;
        prev_we    = we;
        prev_addr  = addr;
        prev_wdata = wdata;
        prev_ready = mem_ready;
    end

endmodule

`default_nettype wire

//--- src/bus_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package bus_pkg;

    // One request toward the shared memory bus
    typedef struct packed {
        logic                   req;
        logic                   we;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

//--- src/decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module decode (
    input  wire                        clk,
    input  wire                        en,
    input  wire [`CPU_INST_W-1:0]      inst,
    output isa_pkg::decoded_t          dec,
    output logic                       ready
);

    isa_pkg::opcode_e                op;
    logic [isa_pkg::REG_IDX_W-1:0]   r0;
    logic [isa_pkg::REG_IDX_W-1:0]   r1;
    logic [isa_pkg::REG_IDX_W-1:0]   r2;
    logic [`CPU_DATA_W-1:0]          imm;

    // Fields from the top: op, r0, r1, r2
    always_comb begin
        op = isa_pkg::opcode_e'(inst[`CPU_INST_W-1 -: 4]);
        r0 = inst[`CPU_INST_W-5 -: isa_pkg::REG_IDX_W];
        r1 = inst[`CPU_INST_W-9 -: isa_pkg::REG_IDX_W];
        r2 = inst[isa_pkg::REG_IDX_W-1:0];

        // LODI and JMP carry a full byte, ADDI only the r2 nibble
        if (op == isa_pkg::LODI || op == isa_pkg::JMP)
            imm = inst[`CPU_DATA_W-1:0];
        else
            imm = `CPU_DATA_W'(r2);
    end

    // One cycle from en to ready
    always_ff @(posedge clk) begin
        ready <= en;
        if (en) begin
            dec.op  <= op;
            dec.r0  <= r0;
            dec.r1  <= r1;
            dec.r2  <= r2;
            dec.imm <= imm;
        end
    end

endmodule

`default_nettype wire

//--- src/eightbit.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module eightbit (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         mem_ready,
    input  wire [`CPU_DATA_W-1:0]       data_in,
    output logic                        mem_req,
    output logic                        we,
    output logic [`CPU_ADDR_W-1:0]      addr,
    output logic [`CPU_DATA_W-1:0]      data_out
);

    logic [`CPU_ADDR_W-1:0]                    pc;
    logic                                      fetch_en;
    logic                                      fetch_ready;
    logic                                      fetch_mem_ready;
    logic [`CPU_INST_W-1:0]                    fetch_inst;
    logic [`CPU_INST_W-1:0]                    decode_inst;
    logic                                      decode_en;
    logic                                      decode_ready;
    logic                                      exec_en;
    logic                                      exec_ready;
    logic                                      exec_mem_ready;
    logic                                      exec_flush;
    isa_pkg::opcode_e                          exec_op;
    logic [`CPU_DATA_W-1:0]                    exec_a;
    logic [`CPU_DATA_W-1:0]                    exec_b;
    logic [`CPU_DATA_W-1:0]                    exec_imm;
    logic [isa_pkg::REG_IDX_W-1:0]             exec_rd;
    logic [`CPU_ADDR_W-1:0]                    exec_pc_target;
    logic                                      wb_en;
    logic                                      wb_ready;
    logic [`CPU_NUM_REGS*`CPU_DATA_W-1:0]      regs;
    logic [`CPU_NUM_REGS-1:0][`CPU_DATA_W-1:0] rf_view;
    logic                                      fetch_held;
    logic                                      exec_held;
    logic                                      grant_exec;
    logic                                      take_fetch;
    logic                                      take_decode;
    logic                                      take_exec;
    logic                                      branch;
    logic                                      reads_r0;
    isa_pkg::decoded_t                         dec;
    isa_pkg::wb_t                              exec_wb;
    isa_pkg::wb_t                              wb_in;
    bus_pkg::mem_req_t                         fetch_bus;
    bus_pkg::mem_req_t                         exec_bus;
    bus_pkg::mem_req_t                         bus_out;

    fetch fetch_i (
        .clk       (clk),
        .rst       (rst),
        .en        (fetch_en),
        .pc        (pc),
        .mem_ready (fetch_mem_ready),
        .data_in   (data_in),
        .bus       (fetch_bus),
        .inst      (fetch_inst),
        .ready     (fetch_ready)
    );

    decode decode_i (
        .clk   (clk),
        .en    (decode_en),
        .inst  (decode_inst),
        .dec   (dec),
        .ready (decode_ready)
    );

    exec exec_i (
        .clk       (clk),
        .rst       (rst),
        .en        (exec_en),
        .op        (exec_op),
        .a         (exec_a),
        .b         (exec_b),
        .imm       (exec_imm),
        .mem_ready (exec_mem_ready),
        .data_in   (data_in),
        .bus       (exec_bus),
        .wb        (exec_wb),
        .pc_target (exec_pc_target),
        .flush     (exec_flush),
        .ready     (exec_ready)
    );

    writeback writeback_i (
        .clk   (clk),
        .rst   (rst),
        .en    (wb_en),
        .wb    (wb_in),
        .regs  (regs),
        .ready (wb_ready)
    );

    always_comb begin
        wb_in    = exec_wb;
        wb_in.rd = exec_rd;
    end

    // A stage hands over only when the next one is fully idle
    assign take_fetch  = fetch_en && fetch_ready && !decode_en && !decode_ready;
    assign take_decode = decode_en && decode_ready && !exec_en && !exec_ready &&
                         !wb_en && !wb_ready;
    assign take_exec   = exec_en && exec_ready && !wb_en && !wb_ready;
    assign branch      = take_exec && exec_flush;

    assign rf_view  = regs;
    assign reads_r0 = dec.op inside {isa_pkg::JMP, isa_pkg::STR, isa_pkg::JEQZ};

    // Exec has priority unless fetch is mid-handshake
    assign grant_exec      = exec_held || (!fetch_held && exec_bus.req);
    assign bus_out         = grant_exec ? exec_bus : fetch_bus;
    assign mem_req         = bus_out.req;
    assign we              = bus_out.we;
    assign addr            = bus_out.addr;
    assign data_out        = bus_out.wdata;
    assign exec_mem_ready  = grant_exec && mem_ready;
    assign fetch_mem_ready = !grant_exec && mem_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_held <= 1'b0;
            exec_held  <= 1'b0;
        end else if (exec_held) begin
            if (!exec_bus.req && !mem_ready)
                exec_held <= 1'b0;
        end else if (fetch_held) begin
            if (!fetch_bus.req && !mem_ready)
                fetch_held <= 1'b0;
        end else if (exec_bus.req) begin
            exec_held <= 1'b1;
        end else if (fetch_bus.req) begin
            fetch_held <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc        <= `CPU_RESET_PC;
            fetch_en  <= 1'b0;
            decode_en <= 1'b0;
            exec_en   <= 1'b0;
            wb_en     <= 1'b0;
        end else begin
            if (!fetch_en && !fetch_ready)
                fetch_en <= 1'b1;
            if (take_fetch) begin
                fetch_en  <= 1'b0;
                decode_en <= 1'b1;
                pc        <= pc + `CPU_ADDR_W'(2);
            end
            if (take_decode) begin
                decode_en <= 1'b0;
                exec_en   <= 1'b1;
            end
            if (take_exec) begin
                exec_en <= 1'b0;
                wb_en   <= 1'b1;
            end
            if (wb_en && wb_ready)
                wb_en <= 1'b0;
            if (branch) begin                           // Overrides the fetch handoff
                pc        <= exec_pc_target;
                fetch_en  <= 1'b0;
                decode_en <= 1'b0;
            end
        end
    end

    // Operands are read as exec starts, after writeback has settled
    always_ff @(posedge clk) begin
        if (take_fetch)
            decode_inst <= fetch_inst;
        if (take_decode) begin
            exec_op  <= dec.op;
            exec_rd  <= dec.r0;
            exec_imm <= dec.imm;
            exec_a   <= reads_r0 ? rf_view[dec.r0] : rf_view[dec.r1];
            exec_b   <= reads_r0 ? rf_view[dec.r1] : rf_view[dec.r2];
        end
    end

endmodule

`default_nettype wire

//--- src/exec.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module exec (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          en,
    input  wire isa_pkg::opcode_e        op,
    input  wire [`CPU_DATA_W-1:0]        a,
    input  wire [`CPU_DATA_W-1:0]        b,
    input  wire [`CPU_DATA_W-1:0]        imm,
    input  wire                          mem_ready,
    input  wire [`CPU_DATA_W-1:0]        data_in,
    output bus_pkg::mem_req_t            bus,
    output isa_pkg::wb_t                 wb,
    output logic [`CPU_ADDR_W-1:0]       pc_target,
    output logic                         flush,
    output logic                         ready
);

    typedef enum logic [1:0] {X_IDLE, X_REQ, X_WAIT, X_DONE} state_e;

    state_e                 state;
    logic                   req_q;
    logic                   we_q;
    logic                   wr_en_q;
    logic [`CPU_ADDR_W-1:0] addr_q;
    logic [`CPU_DATA_W-1:0] wdata_q;
    logic [`CPU_DATA_W-1:0] val_q;
    logic [`CPU_DATA_W-1:0] alu;
    logic                   writes;
    logic                   taken;
    logic                   is_mem;

    always_comb begin
        alu    = '0;
        writes = 1'b1;
        taken  = 1'b0;
        case (op)
            isa_pkg::ADD:  alu = a + b;
            isa_pkg::ADDI: alu = a + imm;
            isa_pkg::LODI: alu = imm;
            isa_pkg::NAND: alu = ~(a & b);
            isa_pkg::LOD:  alu = '0;                    // Value comes from memory
            isa_pkg::JMP:  begin
                writes = 1'b0;
                taken  = 1'b1;
            end
            isa_pkg::JEQZ: begin
                writes = 1'b0;
                taken  = (b == '0);
            end
            default:       writes = 1'b0;
        endcase
    end

    assign is_mem = (op == isa_pkg::LOD) || (op == isa_pkg::STR);

    assign bus = '{req: req_q, we: we_q, addr: addr_q, wdata: wdata_q};
    assign wb  = '{wr_en: wr_en_q, rd: '0, val: val_q};   // rd is tracked by the top level

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= X_IDLE;
            req_q   <= 1'b0;
            we_q    <= 1'b0;
            wr_en_q <= 1'b0;
            flush   <= 1'b0;
            ready   <= 1'b0;
        end else begin
            case (state)
                X_IDLE: begin
                    if (en) begin
                        flush   <= taken;
                        wr_en_q <= writes;
                        if (is_mem) begin
                            req_q <= 1'b1;
                            we_q  <= (op == isa_pkg::STR);
                            state <= X_REQ;
                        end else begin
                            ready <= 1'b1;
                            state <= X_DONE;
                        end
                    end
                end
                X_REQ: begin
                    if (mem_ready) begin
                        req_q <= 1'b0;
                        we_q  <= 1'b0;
                        state <= X_WAIT;
                    end
                end
                X_WAIT: begin
                    if (!mem_ready) begin
                        ready <= 1'b1;
                        state <= X_DONE;
                    end
                end
                X_DONE: begin
                    if (!en) begin
                        ready <= 1'b0;
                        state <= X_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == X_IDLE && en) begin
            val_q     <= alu;
            pc_target <= a;
            addr_q    <= (op == isa_pkg::STR) ? b : a;  // STR addresses R[r1]
            wdata_q   <= a;
        end
        if (state == X_REQ && mem_ready && !we_q)
            val_q <= data_in;
    end

endmodule

`default_nettype wire

//--- src/fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module fetch (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          en,
    input  wire [`CPU_ADDR_W-1:0]        pc,
    input  wire                          mem_ready,
    input  wire [`CPU_DATA_W-1:0]        data_in,
    output bus_pkg::mem_req_t            bus,
    output logic [`CPU_INST_W-1:0]       inst,
    output logic                         ready
);

    typedef enum logic [1:0] {F_IDLE, F_REQ, F_WAIT, F_DONE} state_e;

    state_e                 state;
    logic                   req_q;
    logic                   second;   // Low byte in flight
    logic                   stale;    // Cancelled while the bus was busy
    logic [`CPU_ADDR_W-1:0] addr_q;
    logic [`CPU_DATA_W-1:0] hi_byte;
    logic [`CPU_DATA_W-1:0] lo_byte;

    assign bus  = '{req: req_q, we: 1'b0, addr: addr_q, wdata: '0};
    assign inst = {hi_byte, lo_byte};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= F_IDLE;
            req_q  <= 1'b0;
            second <= 1'b0;
            stale  <= 1'b0;
            ready  <= 1'b0;
        end else begin
            case (state)
                F_IDLE: begin
                    stale <= 1'b0;
                    if (en) begin
                        req_q  <= 1'b1;
                        second <= 1'b0;
                        state  <= F_REQ;
                    end
                end
                F_REQ: begin
                    if (!en)
                        stale <= 1'b1;
                    if (mem_ready) begin
                        req_q <= 1'b0;
                        state <= F_WAIT;
                    end
                end
                F_WAIT: begin
                    if (!mem_ready) begin
                        if (stale || !en) begin
                            state <= F_IDLE;            // Drop the half fetched word
                        end else if (second) begin
                            ready <= 1'b1;
                            state <= F_DONE;
                        end else begin
                            req_q  <= 1'b1;
                            second <= 1'b1;
                            state  <= F_REQ;
                        end
                    end else if (!en) begin
                        stale <= 1'b1;
                    end
                end
                F_DONE: begin
                    if (!en) begin
                        ready <= 1'b0;
                        state <= F_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == F_IDLE && en)
            addr_q <= pc;
        else if (state == F_WAIT && !mem_ready && !second)
            addr_q <= addr_q + 1'b1;                    // pc+1 holds the low byte
        if (state == F_REQ && mem_ready) begin
            if (second)
                lo_byte <= data_in;
            else
                hi_byte <= data_in;
        end
    end

endmodule

`default_nettype wire

//--- src/isa_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package isa_pkg;

    localparam int REG_IDX_W = $clog2(`CPU_NUM_REGS);

    typedef enum logic [3:0] {
        JMP  = 4'd0,
        LOD  = 4'd1,
        STR  = 4'd2,
        ADD  = 4'd3,
        ADDI = 4'd4,
        LODI = 4'd5,
        NAND = 4'd6,
        JEQZ = 4'd7
    } opcode_e;

    typedef struct packed {
        opcode_e                op;
        logic [REG_IDX_W-1:0]   r0;
        logic [REG_IDX_W-1:0]   r1;
        logic [REG_IDX_W-1:0]   r2;
        logic [`CPU_DATA_W-1:0] imm;
    } decoded_t;

    typedef struct packed {
        logic                   wr_en;
        logic [REG_IDX_W-1:0]   rd;
        logic [`CPU_DATA_W-1:0] val;
    } wb_t;

endpackage

`default_nettype wire

//--- src/writeback.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module writeback (
    input  wire                                      clk,
    input  wire                                      rst,
    input  wire                                      en,
    input  wire isa_pkg::wb_t                        wb,
    output logic [`CPU_NUM_REGS*`CPU_DATA_W-1:0]     regs,
    output logic                                     ready
);

    logic [`CPU_NUM_REGS-1:0][`CPU_DATA_W-1:0] rf;
    logic                                      do_write;

    assign regs = rf;

    // Single write on the first cycle of en
    assign do_write = en && !ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rf    <= '0;
            ready <= 1'b0;
        end else begin
            ready <= do_write;                          // One cycle pulse
            if (do_write && wb.wr_en)
                rf[wb.rd] <= wb.val;
        end
    end

endmodule

`default_nettype wire
